// File: include/snake_consts.svh
`ifndef SNAKE_CONSTS_SVH
`define SNAKE_CONSTS_SVH

// Playfield extent in cells
`define SNAKE_GRID_W 32
`define SNAKE_GRID_H 24

// Coordinate width, one spare bit so a step off the low edge wraps high
`define SNAKE_COORD_W 6

// Body register count and length after start
`define SNAKE_MAX_LEN 8
`define SNAKE_START_LEN 3

// Credits held after reset, matches display engine buffer depth
`define DRAW_CREDITS 4

`endif

// File: verilog/snake_types_pkg.sv
`default_nettype none
`include "snake_consts.svh"

package snake_types_pkg;

    ////////////////////
    // Grid point
    ////////////////////
    typedef struct packed {
        logic [`SNAKE_COORD_W-1:0] x;
        logic [`SNAKE_COORD_W-1:0] y;
    } point_t;

    // Heading, DOWN increases y
    typedef enum logic [1:0] {
        RIGHT,
        DOWN,
        LEFT,
        UP
    } dir_e;

    // Game FSM states
    typedef enum logic [1:0] {
        IDLE,
        RUN,
        OVER
    } game_state_e;

    // Settings seen by the game
    typedef struct packed {
        logic [15:0] interval;
        point_t      food;
        logic        food_valid;
    } cfg_t;

endpackage

`default_nettype wire

// File: verilog/draw_pkg.sv
`default_nettype none

package draw_pkg;

    ////////////////////
    // Display link
    ////////////////////

    // Commands understood by the display engine
    typedef enum logic [1:0] {
        DRAW_HEAD,
        ERASE_TAIL,
        GAME_OVER
    } draw_op_e;

    // One command, cell is don't care for GAME_OVER
    typedef struct packed {
        draw_op_e                 op;
        snake_types_pkg::point_t  pt;
    } draw_cmd_t;

endpackage

`default_nettype wire

// File: verilog/snake_config.sv
`timescale 1ns/100ps
`default_nettype none
`include "snake_consts.svh"

module snake_config (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  cfg_wr,
    input  logic [1:0]            cfg_addr,
    input  logic [15:0]           cfg_wdata,
    input  logic                  food_eaten,
    output snake_types_pkg::cfg_t cfg,
    output logic                  start
);
    import snake_types_pkg::*;

    // Register map
    localparam logic [1:0] ADDR_INTERVAL = 2'd0;
    localparam logic [1:0] ADDR_FOOD = 2'd1;
    localparam logic [1:0] ADDR_START = 2'd2;

    // Step interval until software writes one
    localparam logic [15:0] DEFAULT_INTERVAL = 16'd15;

    logic [15:0] interval_q;
    point_t      food_q;
    logic        food_valid_q;

    // Control registers
    always_ff @(posedge clk) begin
        if (reset) begin
            interval_q <= DEFAULT_INTERVAL;
            food_valid_q <= 1'b0;
            start <= 1'b0;
        end else begin
            start <= cfg_wr && (cfg_addr == ADDR_START);
            if (cfg_wr && (cfg_addr == ADDR_INTERVAL)) begin
                interval_q <= cfg_wdata;
            end
            // New food wins over a same-cycle eat
            if (cfg_wr && (cfg_addr == ADDR_FOOD)) begin
                food_valid_q <= 1'b1;
            end else if (food_eaten) begin
                food_valid_q <= 1'b0;
            end
        end
    end

    // Food cell, x in low byte and y in high byte
    always_ff @(posedge clk) begin
        if (cfg_wr && (cfg_addr == ADDR_FOOD)) begin
            food_q.x <= cfg_wdata[`SNAKE_COORD_W-1:0];
            food_q.y <= cfg_wdata[8+`SNAKE_COORD_W-1:8];
        end
    end

    always_comb begin
        cfg.interval = interval_q;
        cfg.food = food_q;
        cfg.food_valid = food_valid_q;
    end

endmodule

`default_nettype wire

// File: verilog/snake_body.sv
`timescale 1ns/100ps
`default_nettype none
`include "snake_consts.svh"

module snake_body (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    step,
    input  logic                    grow,
    input  snake_types_pkg::point_t new_head,
    output snake_types_pkg::point_t head,
    output snake_types_pkg::point_t neck,
    output snake_types_pkg::point_t tail,
    output logic                    hit
);
    import snake_types_pkg::*;

    localparam int LEN_W = $clog2(`SNAKE_MAX_LEN + 1);
    localparam int IDX_W = $clog2(`SNAKE_MAX_LEN);

    // Segment 0 is the head
    point_t seg [`SNAKE_MAX_LEN];

    logic [LEN_W-1:0] len;
    logic [LEN_W-1:0] live;
    logic [IDX_W-1:0] tail_idx;
    logic             full;

    assign full = (len == LEN_W'(`SNAKE_MAX_LEN));

    ////////////////////
    // Segment shift
    ////////////////////

    // At full length the oldest point falls off, even on grow
    always_ff @(posedge clk) begin
        if (step) begin
            seg[0] <= new_head;
            for (int i = 1; i < `SNAKE_MAX_LEN; i++) begin
                seg[i] <= seg[i-1];
            end
        end
    end

    // Length only moves on growing steps
    always_ff @(posedge clk) begin
        if (reset) begin
            len <= '0;
        end else if (step && grow && !full) begin
            len <= len + 1'b1;
        end
    end

    ////////////////////
    // Views and compare
    ////////////////////

    always_comb begin
        if (len == '0) begin
            tail_idx = '0;
        end else begin
            tail_idx = IDX_W'(len - 1'b1);
        end
    end

    assign head = seg[0];
    assign neck = seg[1];
    assign tail = seg[tail_idx];

    // Segments still occupied after this step
    // Tail cell is vacated unless the snake really grows
    always_comb begin
        if (len == '0) begin
            live = '0;
        end else if (grow && !full) begin
            live = len;
        end else begin
            live = len - 1'b1;
        end
    end

    // Offered head against every live segment
    always_comb begin
        hit = 1'b0;
        for (int i = 0; i < `SNAKE_MAX_LEN; i++) begin
            if ((LEN_W'(i) < live) && (seg[i] == new_head)) begin
                hit = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/snake_game.sv
`timescale 1ns/100ps
`default_nettype none
`include "snake_consts.svh"

module snake_game (
    input  logic                         clk,
    input  logic                         reset,
    input  snake_types_pkg::cfg_t        cfg,
    input  logic                         start,
    input  snake_types_pkg::dir_e        dir_in,
    input  snake_types_pkg::point_t      head,
    input  snake_types_pkg::point_t      neck,
    input  snake_types_pkg::point_t      tail,
    input  logic                         hit,
    input  logic [2:0]                   free_slots,
    output logic                         step,
    output logic                         grow,
    output logic                         food_eaten,
    output logic                         ev_push,
    output snake_types_pkg::point_t      new_head,
    output draw_pkg::draw_cmd_t          ev_cmd,
    output snake_types_pkg::game_state_e state
);
    import snake_types_pkg::*;
    import draw_pkg::*;

    // Initial head cell, body extends to the left
    localparam int START_X = 4;
    localparam int START_Y = 4;

    localparam int LEN_W = $clog2(`SNAKE_MAX_LEN + 1);

    logic [15:0]      interval_cnt;
    dir_e             cur_dir;
    dir_e             move_dir;
    logic             loading;
    logic [1:0]       load_idx;
    logic             head_pending;
    point_t           load_pt;
    point_t           want_pt;
    point_t           keep_pt;
    point_t           move_pt;
    logic             due;
    logic             step_fire;
    logic             load_go;
    logic             wall;
    logic             collide;
    logic             food_hit;
    logic             growing;
    logic [LEN_W-1:0] body_len;

    // One cell in the given heading
    function automatic point_t advance(point_t p, dir_e d);
        point_t q;
        q = p;
        case (d)
            RIGHT: q.x = p.x + 1'b1;
            DOWN: q.y = p.y + 1'b1;
            LEFT: q.x = p.x - 1'b1;
            default: q.y = p.y - 1'b1;
        endcase
        return q;
    endfunction

    ////////////////////
    // Next head
    ////////////////////

    // Reversal onto the neck keeps the old heading
    always_comb begin
        want_pt = advance(head, dir_in);
        keep_pt = advance(head, cur_dir);
        if (want_pt == neck) begin
            move_pt = keep_pt;
            move_dir = cur_dir;
        end else begin
            move_pt = want_pt;
            move_dir = dir_in;
        end
    end

    // Start segments, tail first
    assign load_pt.x = `SNAKE_COORD_W'(START_X - `SNAKE_START_LEN + 1 + int'(load_idx));
    assign load_pt.y = `SNAKE_COORD_W'(START_Y);

    // Off the low edge wraps to a large value
    assign wall = (move_pt.x >= `SNAKE_COORD_W'(`SNAKE_GRID_W)) ||
                  (move_pt.y >= `SNAKE_COORD_W'(`SNAKE_GRID_H));
    assign collide = wall || hit;
    assign food_hit = cfg.food_valid && (move_pt == cfg.food);

    // Eating at full length does not grow
    assign growing = food_hit && (body_len < LEN_W'(`SNAKE_MAX_LEN));

    // Step needs room for erase plus head
    assign due = (state == RUN) && !head_pending && (interval_cnt >= cfg.interval);
    assign step_fire = due && (free_slots >= 3'd2);
    assign load_go = loading && (free_slots != 3'd0);

    ////////////////////
    // Body and queue
    ////////////////////

    assign new_head = loading ? load_pt : move_pt;
    assign grow = loading || food_hit;
    assign step = load_go || (step_fire && !collide);
    assign food_eaten = step_fire && !collide && food_hit;

    // Step cycle carries erase or game over, head follows a cycle later
    assign ev_push = load_go || head_pending || (step_fire && (collide || !growing));

    always_comb begin
        if (loading) begin
            ev_cmd.op = DRAW_HEAD;
            ev_cmd.pt = load_pt;
        end else if (head_pending) begin
            // Body already holds the new head
            ev_cmd.op = DRAW_HEAD;
            ev_cmd.pt = head;
        end else if (collide) begin
            ev_cmd.op = GAME_OVER;
            ev_cmd.pt = move_pt;
        end else begin
            ev_cmd.op = ERASE_TAIL;
            ev_cmd.pt = tail;
        end
    end

    ////////////////////
    // Game FSM
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            cur_dir <= RIGHT;
            loading <= 1'b0;
            load_idx <= '0;
            head_pending <= 1'b0;
            interval_cnt <= '0;
            body_len <= '0;
        end else begin
            head_pending <= step_fire && !collide;
            case (state)
                IDLE: begin
                    if (loading) begin
                        if (load_go) begin
                            load_idx <= load_idx + 1'b1;
                            // Last start segment placed
                            if (load_idx == 2'(`SNAKE_START_LEN - 1)) begin
                                loading <= 1'b0;
                                state <= RUN;
                                cur_dir <= RIGHT;
                                interval_cnt <= '0;
                                body_len <= LEN_W'(`SNAKE_START_LEN);
                            end
                        end
                    end else if (start) begin
                        loading <= 1'b1;
                        load_idx <= '0;
                    end
                end
                RUN: begin
                    if (step_fire) begin
                        interval_cnt <= '0;
                        if (collide) begin
                            state <= OVER;
                        end else begin
                            cur_dir <= move_dir;
                            if (growing) begin
                                body_len <= body_len + 1'b1;
                            end
                        end
                    end else if (!due) begin
                        interval_cnt <= interval_cnt + 1'b1;
                    end
                end
                // Held until reset
                default: begin
                    state <= OVER;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/draw_sender.sv
`timescale 1ns/100ps
`default_nettype none
`include "snake_consts.svh"

module draw_sender (
    input  logic                clk,
    input  logic                reset,
    input  logic                ev_push,
    input  draw_pkg::draw_cmd_t ev_cmd,
    input  logic                credit_return,
    output logic [2:0]          free_slots,
    output logic                cmd_valid,
    output draw_pkg::draw_cmd_t cmd
);
    import draw_pkg::*;

    localparam int DEPTH = 4;

    draw_cmd_t  fifo_mem [DEPTH];
    logic [1:0] wr_ptr;
    logic [1:0] rd_ptr;
    logic [2:0] count;
    logic [2:0] credits;
    logic       do_push;
    logic       do_send;

    ////////////////////
    // Queue
    ////////////////////

    // Push into a full queue is dropped
    assign do_push = ev_push && (count != 3'(DEPTH));

    // Oldest entry goes out when a credit is held
    assign do_send = (count != 3'd0) && (credits != 3'd0);

    assign cmd_valid = do_send;
    assign cmd = fifo_mem[rd_ptr];
    assign free_slots = 3'(DEPTH) - count;

    always_ff @(posedge clk) begin
        if (do_push) begin
            fifo_mem[wr_ptr] <= ev_cmd;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_send) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + {2'b00, do_push} - {2'b00, do_send};
        end
    end

    ////////////////////
    // Credits
    ////////////////////

    // One per free slot in the display engine
    always_ff @(posedge clk) begin
        if (reset) begin
            credits <= 3'(`DRAW_CREDITS);
        end else begin
            credits <= credits + {2'b00, credit_return} - {2'b00, do_send};
        end
    end

endmodule

`default_nettype wire

// File: verilog/snake_top.sv
`timescale 1ns/100ps
`default_nettype none

module snake_top (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         cfg_wr,
    input  logic [1:0]                   cfg_addr,
    input  logic [15:0]                  cfg_wdata,
    input  snake_types_pkg::dir_e        dir_in,
    input  logic                         credit_return,
    output logic                         cmd_valid,
    output draw_pkg::draw_cmd_t          cmd,
    output snake_types_pkg::game_state_e state
);
    import snake_types_pkg::*;
    import draw_pkg::*;

    // Config to game
    cfg_t cfg;
    logic start;
    logic food_eaten;

    // Game and body
    logic   step;
    logic   grow;
    logic   hit;
    point_t new_head;
    point_t head;
    point_t neck;
    point_t tail;

    // Game to sender
    logic       ev_push;
    draw_cmd_t  ev_cmd;
    logic [2:0] free_slots;

    snake_config config_i (
        .clk        (clk),
        .reset      (reset),
        .cfg_wr     (cfg_wr),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .food_eaten (food_eaten),
        .cfg        (cfg),
        .start      (start)
    );

    snake_game game_i (
        .clk        (clk),
        .reset      (reset),
        .cfg        (cfg),
        .start      (start),
        .dir_in     (dir_in),
        .head       (head),
        .neck       (neck),
        .tail       (tail),
        .hit        (hit),
        .free_slots (free_slots),
        .step       (step),
        .grow       (grow),
        .food_eaten (food_eaten),
        .ev_push    (ev_push),
        .new_head   (new_head),
        .ev_cmd     (ev_cmd),
        .state      (state)
    );

    snake_body body_i (
        .clk      (clk),
        .reset    (reset),
        .step     (step),
        .grow     (grow),
        .new_head (new_head),
        .head     (head),
        .neck     (neck),
        .tail     (tail),
        .hit      (hit)
    );

    draw_sender sender_i (
        .clk           (clk),
        .reset         (reset),
        .ev_push       (ev_push),
        .ev_cmd        (ev_cmd),
        .credit_return (credit_return),
        .free_slots    (free_slots),
        .cmd_valid     (cmd_valid),
        .cmd           (cmd)
    );

endmodule

`default_nettype wire

// File: dv/snake_checker.sv
`timescale 1ns/100ps
`default_nettype none
`include "snake_consts.svh"

module snake_checker (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         cfg_wr,
    input  logic [1:0]                   cfg_addr,
    input  logic [15:0]                  cfg_wdata,
    input  snake_types_pkg::dir_e        dir_in,
    input  logic                         credit_return,
    input  logic                         cmd_valid,
    input  draw_pkg::draw_cmd_t          cmd,
    input  snake_types_pkg::game_state_e state,
    input  logic                         row_end,
    input  logic [127:0]                 test_name,
    output int                           error_count
);
    import snake_types_pkg::*;
    import draw_pkg::*;

    // Model body, index 0 is the head
    int       bx [$];
    int       by [$];
    // Commands still to come, oldest first
    draw_op_e exp_op [$];
    int       exp_x [$];
    int       exp_y [$];

    dir_e cur_dir;
    int   food_x;
    int   food_y;
    bit   food_valid;
    bit   running;
    bit   over_pred;
    bit   over_seen;
    int   credits;

    function automatic string fmt_cmd(draw_op_e op, int x, int y);
        return $sformatf("%s(%0d,%0d)", op.name(), x, y);
    endfunction

    task automatic expect_cmd(draw_op_e op, int x, int y);
        exp_op.push_back(op);
        exp_x.push_back(x);
        exp_y.push_back(y);
    endtask

    // One grid step, no wrap in the model
    task automatic move_from(input int x, input int y, input dir_e d, output int nx,
                             output int ny);
        nx = x;
        ny = y;
        case (d)
            RIGHT: nx = x + 1;
            DOWN: ny = y + 1;
            LEFT: nx = x - 1;
            default: ny = y - 1;
        endcase
    endtask

    ////////////////////
    // Step prediction
    ////////////////////

    task automatic predict_step(input dir_e req);
        int   nx;
        int   ny;
        int   live;
        bit   wall;
        bit   hit;
        bit   eat;
        bit   growing;
        dir_e d;
        d = req;
        move_from(bx[0], by[0], req, nx, ny);
        // Reversal onto the neck keeps heading
        if (nx == bx[1] && ny == by[1]) begin
            d = cur_dir;
            move_from(bx[0], by[0], cur_dir, nx, ny);
        end
        wall = (nx < 0) || (nx >= `SNAKE_GRID_W) || (ny < 0) || (ny >= `SNAKE_GRID_H);
        eat = food_valid && (nx == food_x) && (ny == food_y);
        growing = eat && (bx.size() < `SNAKE_MAX_LEN);
        // Tail leaves unless really growing
        live = growing ? bx.size() : bx.size() - 1;
        hit = 1'b0;
        for (int i = 0; i < live; i++) begin
            if (bx[i] == nx && by[i] == ny) begin
                hit = 1'b1;
            end
        end
        if (wall || hit) begin
            expect_cmd(GAME_OVER, nx, ny);
            over_pred = 1'b1;
        end else begin
            if (!growing) begin
                expect_cmd(ERASE_TAIL, bx[bx.size()-1], by[by.size()-1]);
            end
            expect_cmd(DRAW_HEAD, nx, ny);
            bx.push_front(nx);
            by.push_front(ny);
            // At full length the oldest drops even when eating
            if (!growing) begin
                void'(bx.pop_back());
                void'(by.pop_back());
            end
            if (eat) begin
                food_valid = 1'b0;
            end
            cur_dir = d;
        end
    endtask

    ////////////////////
    // Monitor
    ////////////////////

    always @(posedge clk) begin
        draw_op_e    eop;
        int          ex;
        int          ey;
        game_state_e want_state;
        if (reset) begin
            bx.delete();
            by.delete();
            exp_op.delete();
            exp_x.delete();
            exp_y.delete();
            food_valid = 1'b0;
            running = 1'b0;
            over_pred = 1'b0;
            over_seen = 1'b0;
            cur_dir = RIGHT;
            credits = `DRAW_CREDITS;
        end else begin
            if (cfg_wr && cfg_addr == 2'd1) begin
                food_x = int'(cfg_wdata[`SNAKE_COORD_W-1:0]);
                food_y = int'(cfg_wdata[8+`SNAKE_COORD_W-1:8]);
                food_valid = 1'b1;
            end
            // Start snake, tail first on the display
            if (cfg_wr && cfg_addr == 2'd2 && !running) begin
                for (int i = 0; i < `SNAKE_START_LEN; i++) begin
                    bx.push_front(4 - `SNAKE_START_LEN + 1 + i);
                    by.push_front(4);
                    expect_cmd(DRAW_HEAD, 4 - `SNAKE_START_LEN + 1 + i, 4);
                end
                cur_dir = RIGHT;
                running = 1'b1;
            end
            if (cmd_valid) begin
                if (credits == 0) begin
                    $display("%0s: command sent with no credit available", test_name);
                    error_count++;
                end
                if (over_seen) begin
                    $display("%0s: command sent after game over", test_name);
                    error_count++;
                end else begin
                    // First command of a new step
                    if (exp_op.size() == 0 && running && !over_pred) begin
                        predict_step(dir_in);
                    end
                    if (exp_op.size() == 0) begin
                        $display("%0s: unexpected command %s", test_name,
                                 fmt_cmd(cmd.op, int'(cmd.pt.x), int'(cmd.pt.y)));
                        error_count++;
                    end else begin
                        eop = exp_op.pop_front();
                        ex = exp_x.pop_front();
                        ey = exp_y.pop_front();
                        // Cell ignored for game over
                        if (cmd.op != eop || (eop != GAME_OVER &&
                            (int'(cmd.pt.x) != ex || int'(cmd.pt.y) != ey))) begin
                            $display("FAILED %0s: expected %s actual %s", test_name,
                                     fmt_cmd(eop, ex, ey),
                                     fmt_cmd(cmd.op, int'(cmd.pt.x), int'(cmd.pt.y)));
                            error_count++;
                        end
                        if (cmd.op == GAME_OVER) begin
                            over_seen = 1'b1;
                        end
                    end
                end
            end
            credits = credits + int'(credit_return) - int'(cmd_valid);
            if (row_end) begin
                want_state = over_pred ? OVER : RUN;
                if (state != want_state) begin
                    $display("FAILED %0s: expected state %s actual %s", test_name,
                             want_state.name(), state.name());
                    error_count++;
                end
                if (exp_op.size() != 0) begin
                    $display("%0s: %0d predicted commands never arrived", test_name,
                             exp_op.size());
                    error_count++;
                end
            end
        end
    end

    initial begin
        error_count = 0;
    end

endmodule

`default_nettype wire

// File: dv/snake_tb.sv
`timescale 1ns/100ps
`default_nettype none
`include "snake_consts.svh"

module snake_tb;
    import snake_types_pkg::*;
    import draw_pkg::*;

    localparam int NUM_ROWS = 6;
    localparam int HOLD_CYCLES = 40;

    // One test row
    typedef struct packed {
        logic [127:0]      name;
        logic [15:0]       interval;
        logic [15:0]       food;
        logic              has_food;
        logic              feed;
        logic              hold;
        logic              expect_over;
        logic [7:0]        steps;
        logic [11:0][1:0]  dirs;
    } row_t;

    logic         clk;
    logic         reset;
    logic         cfg_wr;
    logic [1:0]   cfg_addr;
    logic [15:0]  cfg_wdata;
    dir_e         dir_in;
    logic         credit_return;
    logic         cmd_valid;
    draw_cmd_t    cmd;
    game_state_e  state;
    logic         row_end;
    logic [127:0] test_name;
    int           chk_errors;

    row_t        rows [NUM_ROWS];
    bit          table_ready;
    bit          hold_credits;
    int          tb_errors;
    int          cycle;
    logic [31:0] lcg_state;
    int          credit_due [$];
    // Observed at the DUT output
    int          head_count;
    int          sends_total;
    bit          over_seen;
    int          last_x;
    int          last_y;

    snake_top dut_i (
        .clk           (clk),
        .reset         (reset),
        .cfg_wr        (cfg_wr),
        .cfg_addr      (cfg_addr),
        .cfg_wdata     (cfg_wdata),
        .dir_in        (dir_in),
        .credit_return (credit_return),
        .cmd_valid     (cmd_valid),
        .cmd           (cmd),
        .state         (state)
    );

    snake_checker checker_i (
        .clk           (clk),
        .reset         (reset),
        .cfg_wr        (cfg_wr),
        .cfg_addr      (cfg_addr),
        .cfg_wdata     (cfg_wdata),
        .dir_in        (dir_in),
        .credit_return (credit_return),
        .cmd_valid     (cmd_valid),
        .cmd           (cmd),
        .state         (state),
        .row_end       (row_end),
        .test_name     (test_name),
        .error_count   (chk_errors)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic row_t make_row(logic [127:0] name, int interval, int fx, int fy,
                                      bit has_food, bit feed, bit hold, bit over,
                                      string dirs);
        row_t r;
        r = '0;
        r.name = name;
        r.interval = 16'(interval);
        r.food = {8'(fy), 8'(fx)};
        r.has_food = has_food;
        r.feed = feed;
        r.hold = hold;
        r.expect_over = over;
        r.steps = 8'(dirs.len());
        for (int i = 0; i < dirs.len(); i++) begin
            case (dirs[i])
                "R": r.dirs[i] = RIGHT;
                "D": r.dirs[i] = DOWN;
                "L": r.dirs[i] = LEFT;
                default: r.dirs[i] = UP;
            endcase
        end
        return r;
    endfunction

    ////////////////////
    // Stimulus table
    ////////////////////

    task automatic build_table();
        rows[0] = make_row("straight", 8, 0, 0, 0, 0, 0, 0, "RRRRR");
        // Third request is a reversal onto the neck
        rows[1] = make_row("turns", 8, 0, 0, 0, 0, 0, 0, "RDULLU");
        rows[2] = make_row("food", 8, 6, 4, 1, 0, 0, 0, "RRRRRRRR");
        rows[3] = make_row("wall", 6, 0, 0, 0, 0, 0, 1, "UUUUUU");
        // Fed every step, caps at full length then bites itself
        rows[4] = make_row("grow_hit", 8, 0, 0, 0, 1, 0, 1, "RRRRRDLU");
        rows[5] = make_row("backpress", 2, 0, 0, 0, 0, 1, 0, "RRRRRRRR");
    endtask

    // Credit return after a pseudo random delay
    always @(posedge clk) begin
        cycle++;
        if (!reset && cmd_valid) begin
            lcg_state = lcg_next(lcg_state);
            credit_due.push_back(cycle + 1 + int'((lcg_state >> 16) % 6));
        end
    end

    always @(negedge clk) begin
        credit_return = 1'b0;
        if (reset) begin
            credit_due.delete();
        end else if (!hold_credits && credit_due.size() != 0 && credit_due[0] <= cycle) begin
            credit_return = 1'b1;
            void'(credit_due.pop_front());
        end
    end

    // Output bookkeeping for stimulus timing
    always @(posedge clk) begin
        if (reset) begin
            head_count = 0;
            sends_total = 0;
            over_seen = 1'b0;
        end else if (cmd_valid) begin
            sends_total++;
            if (cmd.op == DRAW_HEAD) begin
                head_count++;
                last_x = int'(cmd.pt.x);
                last_y = int'(cmd.pt.y);
            end else if (cmd.op == GAME_OVER) begin
                over_seen = 1'b1;
            end
        end
    end

    task automatic apply_reset();
        reset = 1'b1;
        cfg_wr = 1'b0;
        row_end = 1'b0;
        hold_credits = 1'b0;
        repeat (3) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic cfg_write(input logic [1:0] addr, input logic [15:0] data);
        cfg_wr = 1'b1;
        cfg_addr = addr;
        cfg_wdata = data;
        @(negedge clk);
        cfg_wr = 1'b0;
    endtask

    // Until enough heads are drawn or the game ends
    task automatic wait_heads(input int target, input int limit);
        int n;
        n = 0;
        while (head_count < target && !over_seen) begin
            @(negedge clk);
            n++;
            if (n > limit) begin
                $display("%0s: timed out waiting for draw head %0d", test_name, target);
                tb_errors++;
                return;
            end
        end
    endtask

    task automatic run_row(input row_t row);
        int   limit;
        int   fx;
        int   fy;
        dir_e d;
        test_name = row.name;
        limit = 4 * (int'(row.interval) + 1) + 60;
        apply_reset();
        dir_in = dir_e'(row.dirs[0]);
        cfg_write(2'd0, row.interval);
        if (row.has_food) begin
            cfg_write(2'd1, row.food);
        end
        hold_credits = row.hold;
        cfg_write(2'd2, 16'd0);
        if (row.hold) begin
            repeat (HOLD_CYCLES) @(negedge clk);
            if (sends_total != `DRAW_CREDITS) begin
                $display("FAILED %0s: expected %0d sends actual %0d", test_name,
                         `DRAW_CREDITS, sends_total);
                tb_errors++;
            end
            hold_credits = 1'b0;
        end
        for (int k = 0; k < int'(row.steps); k++) begin
            wait_heads(`SNAKE_START_LEN + k, limit);
            if (over_seen) begin
                break;
            end
            d = dir_e'(row.dirs[k]);
            dir_in = d;
            if (row.feed) begin
                fx = last_x + (d == RIGHT ? 1 : (d == LEFT ? -1 : 0));
                fy = last_y + (d == DOWN ? 1 : (d == UP ? -1 : 0));
                cfg_write(2'd1, {8'(fy), 8'(fx)});
            end
        end
        wait_heads(`SNAKE_START_LEN + int'(row.steps), limit);
        if (over_seen != row.expect_over) begin
            $display("FAILED %0s: expected game over %0d actual %0d", test_name,
                     row.expect_over, over_seen);
            tb_errors++;
        end
        repeat (2) @(negedge clk);
        row_end = 1'b1;
        @(negedge clk);
        row_end = 1'b0;
        // Room for stray commands after game over
        repeat (2 * (int'(row.interval) + 1) + 8) @(negedge clk);
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        cfg_wr = 1'b0;
        cfg_addr = '0;
        cfg_wdata = '0;
        dir_in = RIGHT;
        credit_return = 1'b0;
        row_end = 1'b0;
        test_name = "reset";
        hold_credits = 1'b0;
        tb_errors = 0;
        cycle = 0;
        lcg_state = 32'h6fc0a335;
        build_table();
        table_ready = 1'b1;
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(rows[r]);
        end
        $display("Errors: %0d total, checker %0d, testbench %0d",
                 chk_errors + tb_errors, chk_errors, tb_errors);
        if (chk_errors + tb_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog sized from the table
    initial begin
        longint limit_ns;
        wait (table_ready);
        limit_ns = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            limit_ns += (longint'(rows[r].steps) * (longint'(rows[r].interval) + 1) + 50) * 10;
        end
        limit_ns = limit_ns * 4;
        #(limit_ns);
        $display("Watchdog expired after %0d ns in %0s", limit_ns, test_name);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+include
verilog/snake_types_pkg.sv
verilog/draw_pkg.sv
verilog/snake_config.sv
verilog/snake_body.sv
verilog/snake_game.sv
verilog/draw_sender.sv
verilog/snake_top.sv
dv/snake_checker.sv
dv/snake_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing -Wno-fatal
TOP       = snake_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Test passed$$"

clean:
	rm -rf $(OBJ_DIR)
